// ==== rename_unit.f ====
rename_arch_pkg.sv
rename_uarch_pkg.sv
map_table.sv
free_list.sv
rename_unit.sv
rename_unit_tb.sv

// ==== Bender.yml ====
package:
  name: rename_unit

dependencies: {}

sources:
  # packages first, then the modules that use them
  - rename_arch_pkg.sv
  - rename_uarch_pkg.sv
  - map_table.sv
  - free_list.sv
  - rename_unit.sv

  # testbench
  - target: simulation
    files:
      - rename_unit_tb.sv

// ==== rename_unit_tb.sv ====
// rename stage testbench with reference model, check task, clock, reset, timeout and directed tests
`timescale 1ns/100ps

module rename_unit_tb;

  localparam int num_pr         = rename_uarch_pkg::default_num_pr;
  localparam int num_rob        = rename_uarch_pkg::default_num_rob;
  localparam int num_regs       = rename_arch_pkg::num_arch_regs;
  localparam int tag_w          = $clog2(num_pr);
  localparam int rob_w          = $clog2(num_rob);
  // tests need well under 600 cycles, so a wide margin
  localparam int timeout_cycles = 2000;

  typedef logic [tag_w-1:0] tag_t;
  typedef logic [rob_w-1:0] rob_idx_t;

  logic                       clock;
  logic                       reset;
  logic                       dispatch;
  rename_arch_pkg::arch_reg_t dest_reg;
  rename_arch_pkg::arch_reg_t src1_reg;
  rename_arch_pkg::arch_reg_t src2_reg;
  rob_idx_t                   rob_idx;
  logic                       complete_en;
  tag_t                       complete_tag;
  rename_arch_pkg::arch_reg_t complete_reg;
  logic                       rollback_en;
  rob_idx_t                   rollback_idx;
  logic                       retire_en;
  tag_t                       retire_tag;
  logic                       stall;
  tag_t                       t_new;
  tag_t                       t_old;
  tag_t                       src1_tag;
  logic                       src1_ready;
  tag_t                       src2_tag;
  logic                       src2_ready;

  // reference map and free list
  int mtag [num_regs];
  bit mready [num_regs];
  // every tag ever queued, head walks along it
  int fl_hist [$];
  int fl_head;
  // per-slot copies
  int ckpt_tag [num_rob][num_regs];
  int ckpt_head [num_rob];

  int cycle_count;
  int error_count;

  rename_unit #(.num_pr(num_pr), .num_rob(num_rob)) i_rename_unit (
    .clock(clock), .reset(reset), .dispatch(dispatch), .dest_reg(dest_reg),
    .src1_reg(src1_reg), .src2_reg(src2_reg), .rob_idx(rob_idx),
    .complete_en(complete_en), .complete_tag(complete_tag), .complete_reg(complete_reg),
    .rollback_en(rollback_en), .rollback_idx(rollback_idx), .retire_en(retire_en),
    .retire_tag(retire_tag), .stall(stall), .t_new(t_new), .t_old(t_old),
    .src1_tag(src1_tag), .src1_ready(src1_ready), .src2_tag(src2_tag),
    .src2_ready(src2_ready)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // hang guard
  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clock);
      cycle_count++;
      if (cycle_count >= timeout_cycles) begin
        $display("Timeout: tests did not finish within %0d cycles", timeout_cycles);
        $display("Simulation FAILED");
        $fatal(1, "run stopped after timeout");
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("Error: %s expected %0d actual %0d", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // reference model rules
  function automatic bit model_stall();
    return (fl_head >= fl_hist.size()) || rollback_en;
  endfunction

  // table bit, zero register, or same-cycle broadcast
  function automatic bit model_ready(input int r);
    return mready[r] || (r == rename_arch_pkg::zero_reg) ||
           (complete_en && (mtag[r] == complete_tag));
  endfunction

  function automatic void model_reset();
    fl_hist.delete();
    for (int t = num_regs; t < num_pr; t++) begin
      fl_hist.push_back(t);
    end
    fl_head = 0;
    for (int r = 0; r < num_regs; r++) begin
      mtag[r]   = r;
      mready[r] = 1'b1;
    end
    for (int s = 0; s < num_rob; s++) begin
      ckpt_head[s] = 0;
      for (int r = 0; r < num_regs; r++) begin
        ckpt_tag[s][r] = r;
      end
    end
  endfunction

  // strobes low unless the caller sets them again in the same step
  task automatic clear_strobes();
    dispatch    <= 1'b0;
    complete_en <= 1'b0;
    rollback_en <= 1'b0;
    retire_en   <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clock);
    clear_strobes();
    reset <= 1'b1;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    model_reset();
  endtask

  // all combinational outputs against the model, at the falling edge
  task automatic check_lookup(input string name);
    check_value({name, " stall"}, model_stall(), stall);
    check_value({name, " t_old"}, mtag[dest_reg], t_old);
    check_value({name, " src1_tag"}, mtag[src1_reg], src1_tag);
    check_value({name, " src1_ready"}, model_ready(src1_reg), src1_ready);
    check_value({name, " src2_tag"}, mtag[src2_reg], src2_tag);
    check_value({name, " src2_ready"}, model_ready(src2_reg), src2_ready);
  endtask

  task automatic lookup_op(input string name, input int r1, input int r2);
    @(posedge clock);
    clear_strobes();
    dest_reg <= rename_arch_pkg::arch_reg_t'(r1);
    src1_reg <= rename_arch_pkg::arch_reg_t'(r1);
    src2_reg <= rename_arch_pkg::arch_reg_t'(r2);
    @(negedge clock);
    check_lookup(name);
  endtask

  task automatic dispatch_op(input string name, input int dest, input int src1,
                             input int src2, input int slot, output int new_tag);
    bit stalled;
    @(posedge clock);
    clear_strobes();
    dispatch <= 1'b1;
    dest_reg <= rename_arch_pkg::arch_reg_t'(dest);
    src1_reg <= rename_arch_pkg::arch_reg_t'(src1);
    src2_reg <= rename_arch_pkg::arch_reg_t'(src2);
    rob_idx  <= rob_idx_t'(slot);
    @(negedge clock);
    check_lookup(name);
    stalled = model_stall();
    new_tag = -1;
    if (!stalled) begin
      check_value({name, " t_new"}, fl_hist[fl_head], t_new);
      new_tag = fl_hist[fl_head];
      fl_head++;
      ckpt_head[slot] = fl_head;
      mtag[dest]   = new_tag;
      mready[dest] = 1'b0;
      // checkpoint is the post-dispatch map
      for (int r = 0; r < num_regs; r++) begin
        ckpt_tag[slot][r] = mtag[r];
      end
    end
  endtask

  task automatic complete_op(input string name, input int r, input int tag, input int src);
    @(posedge clock);
    clear_strobes();
    complete_en  <= 1'b1;
    complete_reg <= rename_arch_pkg::arch_reg_t'(r);
    complete_tag <= tag_t'(tag);
    src1_reg     <= rename_arch_pkg::arch_reg_t'(src);
    src2_reg     <= rename_arch_pkg::arch_reg_t'(src);
    @(negedge clock);
    check_lookup(name);
    // stale tags leave the entry alone
    if (mtag[r] == tag) begin
      mready[r] = 1'b1;
    end
  endtask

  task automatic retire_op(input string name, input int tag);
    @(posedge clock);
    clear_strobes();
    retire_en  <= 1'b1;
    retire_tag <= tag_t'(tag);
    @(negedge clock);
    check_lookup(name);
    fl_hist.push_back(tag);
  endtask

  // dispatch raised too, it must be swallowed by stall
  task automatic rollback_op(input string name, input int slot);
    @(posedge clock);
    clear_strobes();
    rollback_en  <= 1'b1;
    rollback_idx <= rob_idx_t'(slot);
    dispatch     <= 1'b1;
    @(negedge clock);
    check_lookup(name);
    check_value({name, " stall during rollback"}, 1, stall);
    for (int r = 0; r < num_regs; r++) begin
      mtag[r]   = ckpt_tag[slot][r];
      mready[r] = 1'b1;
    end
    fl_head = ckpt_head[slot];
  endtask

  task automatic test_reset_map();
    apply_reset();
    for (int r = 0; r < num_regs; r++) begin
      lookup_op("reset_map", r, num_regs - 1 - r);
      check_value("reset_map identity", r, src1_tag);
      check_value("reset_map ready", 1, src1_ready);
      check_value("reset_map stall", 0, stall);
    end
  endtask

  task automatic test_dispatch_rename();
    int d;
    int prev;
    int tag;
    apply_reset();
    prev = 0;
    for (int i = 0; i < 8; i++) begin
      d = $urandom_range(0, num_regs - 2);
      // src1 reads the previous destination, already renamed
      dispatch_op("dispatch_rename", d, prev, rename_arch_pkg::zero_reg, i, tag);
      check_value("dispatch_rename sequence", num_regs + i, tag);
      prev = d;
    end
    lookup_op("dispatch_rename lookup", prev, prev);
    check_value("dispatch_rename new tag", num_regs + 7, src1_tag);
    check_value("dispatch_rename not ready", 0, src1_ready);
    // zero register takes a tag too but keeps reading ready
    dispatch_op("dispatch_rename zero", rename_arch_pkg::zero_reg, prev, prev, 8, tag);
    check_value("dispatch_rename zero sequence", num_regs + 8, tag);
    lookup_op("dispatch_rename zero lookup", rename_arch_pkg::zero_reg, prev);
    check_value("dispatch_rename zero tag", num_regs + 8, src1_tag);
    check_value("dispatch_rename zero ready", 1, src1_ready);
  endtask

  task automatic test_complete();
    int r;
    int tag_a;
    int tag_b;
    apply_reset();
    r = $urandom_range(0, num_regs - 2);
    dispatch_op("complete", r, rename_arch_pkg::zero_reg, r, 0, tag_a);
    dispatch_op("complete", r, r, r, 1, tag_b);
    complete_op("complete stale", r, tag_a, r);
    lookup_op("complete stale after", r, r);
    check_value("complete stale ignored", 0, src1_ready);
    // matching broadcast forwards in its own cycle
    complete_op("complete match", r, tag_b, r);
    check_value("complete forwarded", 1, src1_ready);
    lookup_op("complete match after", r, r);
    check_value("complete ready kept", 1, src1_ready);
  endtask

  task automatic test_free_exhaust();
    int old_q [$];
    int rel_q [$];
    int pick [4] = '{2, 0, 3, 1};
    int d;
    int tag;
    apply_reset();
    for (int i = 0; i < num_pr - num_regs; i++) begin
      d = $urandom_range(0, num_regs - 2);
      old_q.push_back(mtag[d]);
      dispatch_op("free_exhaust fill", d, d, 0, i % num_rob, tag);
    end
    lookup_op("free_exhaust empty", 0, 1);
    check_value("free_exhaust stall", 1, stall);
    d = $urandom_range(0, num_regs - 2);
    dispatch_op("free_exhaust stalled", d, d, d, 0, tag);
    lookup_op("free_exhaust unchanged", d, d);
    // released out of dispatch order on purpose
    for (int i = 0; i < 4; i++) begin
      rel_q.push_back(old_q[pick[i]]);
      retire_op("free_exhaust retire", old_q[pick[i]]);
    end
    for (int i = 0; i < 4; i++) begin
      d = $urandom_range(0, num_regs - 2);
      dispatch_op("free_exhaust resume", d, d, 0, i, tag);
      check_value("free_exhaust release order", rel_q[i], tag);
    end
  endtask

  task automatic test_rollback();
    int d;
    int tag;
    int slot2_tag;
    apply_reset();
    slot2_tag = 0;
    for (int s = 0; s < 6; s++) begin
      d = $urandom_range(0, num_regs - 2);
      dispatch_op("rollback fill", d, d, 0, s, tag);
      if (s == 2) begin
        slot2_tag = tag;
      end
    end
    rollback_op("rollback", 2);
    // whole map, two registers per cycle
    for (int r = 0; r < num_regs; r += 2) begin
      lookup_op("rollback map", r, r + 1);
      check_value("rollback ready src1", 1, src1_ready);
      check_value("rollback ready src2", 1, src2_ready);
    end
    d = $urandom_range(0, num_regs - 2);
    dispatch_op("rollback resume", d, d, 0, 3, tag);
    check_value("rollback next tag", slot2_tag + 1, tag);
  endtask

  initial begin
    reset        = 1'b1;
    dispatch     = 1'b0;
    dest_reg     = '0;
    src1_reg     = '0;
    src2_reg     = '0;
    rob_idx      = '0;
    complete_en  = 1'b0;
    complete_tag = '0;
    complete_reg = '0;
    rollback_en  = 1'b0;
    rollback_idx = '0;
    retire_en    = 1'b0;
    retire_tag   = '0;
    error_count  = 0;
    void'($urandom(32'hc8ff));
    test_reset_map();
    test_dispatch_rename();
    test_complete();
    test_free_exhaust();
    test_rollback();
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== rename_unit.sv ====
// rename stage top with dispatch hazard gating around map table and free list
`timescale 1ns/100ps

module rename_unit #(
  parameter int num_pr  = rename_uarch_pkg::default_num_pr,
  parameter int num_rob = rename_uarch_pkg::default_num_rob
) (
  clock,
  reset,
  dispatch,
  dest_reg,
  src1_reg,
  src2_reg,
  rob_idx,
  complete_en,
  complete_tag,
  complete_reg,
  rollback_en,
  rollback_idx,
  retire_en,
  retire_tag,
  stall,
  t_new,
  t_old,
  src1_tag,
  src1_ready,
  src2_tag,
  src2_ready
);

  localparam int tag_w = $clog2(num_pr);
  localparam int rob_w = $clog2(num_rob);

  typedef logic [tag_w-1:0] tag_t;
  typedef logic [rob_w-1:0] rob_idx_t;

  input  logic                       clock;
  input  logic                       reset;
  input  logic                       dispatch;
  input  rename_arch_pkg::arch_reg_t dest_reg;
  input  rename_arch_pkg::arch_reg_t src1_reg;
  input  rename_arch_pkg::arch_reg_t src2_reg;
  input  rob_idx_t                   rob_idx;
  input  logic                       complete_en;
  input  tag_t                       complete_tag;
  input  rename_arch_pkg::arch_reg_t complete_reg;
  input  logic                       rollback_en;
  input  rob_idx_t                   rollback_idx;
  input  logic                       retire_en;
  input  tag_t                       retire_tag;
  output logic                       stall;
  output tag_t                       t_new;
  output tag_t                       t_old;
  output tag_t                       src1_tag;
  output logic                       src1_ready;
  output tag_t                       src2_tag;
  output logic                       src2_ready;

  logic available;
  logic dispatch_fire;

  // wrap-bit pointers need power-of-two sizes
  if ((num_pr <= rename_arch_pkg::num_arch_regs) || ((num_pr & (num_pr - 1)) != 0) ||
      ((num_rob & (num_rob - 1)) != 0)) begin : g_size_check
    $error("rename_unit: num_pr and num_rob must be powers of two, num_pr above 32");
  end

  // no free tag, or recovery in progress
  assign stall         = !available || rollback_en;
  assign dispatch_fire = dispatch && !stall;

  map_table #(.num_pr(num_pr), .num_rob(num_rob)) i_map_table (
    .clock(clock), .reset(reset), .dispatch_en(dispatch_fire), .dest_reg(dest_reg),
    .src1_reg(src1_reg), .src2_reg(src2_reg), .t_new(t_new), .rob_idx(rob_idx),
    .complete_en(complete_en), .complete_tag(complete_tag), .complete_reg(complete_reg),
    .rollback_en(rollback_en), .rollback_idx(rollback_idx), .t_old(t_old),
    .src1_tag(src1_tag), .src1_ready(src1_ready), .src2_tag(src2_tag),
    .src2_ready(src2_ready)
  );

  // retired old tags go back here only
  free_list #(.num_pr(num_pr), .num_rob(num_rob)) i_free_list (
    .clock(clock), .reset(reset), .allocate(dispatch_fire), .rob_idx(rob_idx),
    .release_en(retire_en), .retire_tag(retire_tag), .rollback_en(rollback_en),
    .rollback_idx(rollback_idx), .t_new(t_new), .available(available)
  );

endmodule

// ==== free_list.sv ====
// free physical tag queue with allocate, release and per-slot checkpointed read pointer
`timescale 1ns/100ps

module free_list #(
  parameter int num_pr  = rename_uarch_pkg::default_num_pr,
  parameter int num_rob = rename_uarch_pkg::default_num_rob
) (
  clock,
  reset,
  allocate,
  rob_idx,
  release_en,
  retire_tag,
  rollback_en,
  rollback_idx,
  t_new,
  available
);

  localparam int tag_w    = $clog2(num_pr);
  localparam int rob_w    = $clog2(num_rob);
  localparam int ptr_w    = tag_w + 1;
  localparam int num_free = num_pr - rename_arch_pkg::num_arch_regs;

  typedef logic [tag_w-1:0] tag_t;
  typedef logic [rob_w-1:0] rob_idx_t;

  // queue index plus wrap bit
  typedef logic [ptr_w-1:0] ptr_t;

  input  logic     clock;
  input  logic     reset;
  input  logic     allocate;
  input  rob_idx_t rob_idx;
  input  logic     release_en;
  input  tag_t     retire_tag;
  input  logic     rollback_en;
  input  rob_idx_t rollback_idx;
  output tag_t     t_new;
  output logic     available;

  tag_t fifo [num_pr];
  ptr_t rd_ptr;
  ptr_t wr_ptr;
  ptr_t rd_ptr_inc;
  ptr_t count;

  // head just after each slot's allocation
  ptr_t saved_rd [num_rob];

  assign rd_ptr_inc = rd_ptr + ptr_t'(1);
  assign count      = wr_ptr - rd_ptr;
  assign available  = (count != '0);

  // head tag offered every cycle
  assign t_new = fifo[rd_ptr[tag_w-1:0]];

  // head moves on allocate, jumps back on rollback
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (rollback_en) begin
      rd_ptr <= saved_rd[rollback_idx];
    end else if (allocate) begin
      rd_ptr <= rd_ptr_inc;
    end
  end

  // tail only grows
  // retired tags are real frees even while a rollback happens
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= ptr_t'(num_free);
    end else if (release_en) begin
      wr_ptr <= wr_ptr + ptr_t'(1);
    end
  end

  // identity checkpoints after reset go with an empty head offset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < num_rob; s++) begin
        saved_rd[s] <= '0;
      end
    end else if (allocate) begin
      saved_rd[rob_idx] <= rd_ptr_inc;
    end
  end

  // tags 32 and up in order
  // slots past the tail wrap to low tags and get overwritten by releases before use
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_pr; i++) begin
        fifo[i] <= tag_t'(i + rename_arch_pkg::num_arch_regs);
      end
    end else if (release_en) begin
      fifo[wr_ptr[tag_w-1:0]] <= retire_tag;
    end
  end

  // top must gate allocate with available
  assert property (@(posedge clock) disable iff (reset) allocate |-> available)
    else $error("free_list: allocate from an empty queue");

  // every free tag already queued, a further release is a double free
  assert property (@(posedge clock) disable iff (reset)
                   release_en |-> (count != ptr_t'(num_free)))
    else $error("free_list: release into a full queue");

  // restored head must agree with the tail the rob has built since
  assert property (@(posedge clock) disable iff (reset)
                   rollback_en |=> (count <= ptr_t'(num_free)))
    else $error("free_list: rollback left more free tags than exist");

endmodule

// ==== map_table.sv ====
// rename map table with ready bits, completion update, per-slot checkpoints and rollback restore
`timescale 1ns/100ps

module map_table #(
  parameter int num_pr  = rename_uarch_pkg::default_num_pr,
  parameter int num_rob = rename_uarch_pkg::default_num_rob
) (
  clock,
  reset,
  dispatch_en,
  dest_reg,
  src1_reg,
  src2_reg,
  t_new,
  rob_idx,
  complete_en,
  complete_tag,
  complete_reg,
  rollback_en,
  rollback_idx,
  t_old,
  src1_tag,
  src1_ready,
  src2_tag,
  src2_ready
);

  localparam int tag_w    = $clog2(num_pr);
  localparam int rob_w    = $clog2(num_rob);
  localparam int num_regs = rename_arch_pkg::num_arch_regs;

  // physical tag and reorder buffer slot
  typedef logic [tag_w-1:0] tag_t;
  typedef logic [rob_w-1:0] rob_idx_t;

  // whole map, one tag per architectural register
  typedef tag_t [num_regs-1:0] map_t;

  input  logic                      clock;
  input  logic                      reset;

  // dispatch side, already gated by the top
  input  logic                      dispatch_en;
  input  rename_arch_pkg::arch_reg_t dest_reg;
  input  rename_arch_pkg::arch_reg_t src1_reg;
  input  rename_arch_pkg::arch_reg_t src2_reg;
  input  tag_t                      t_new;
  input  rob_idx_t                  rob_idx;

  // completion bus broadcast
  input  logic                      complete_en;
  input  tag_t                      complete_tag;
  input  rename_arch_pkg::arch_reg_t complete_reg;

  // mispredict recovery
  input  logic                      rollback_en;
  input  rob_idx_t                  rollback_idx;

  // lookups
  output tag_t                      t_old;
  output tag_t                      src1_tag;
  output logic                      src1_ready;
  output tag_t                      src2_tag;
  output logic                      src2_ready;

  // current map
  map_t                map_tag;
  logic [num_regs-1:0] map_ready;

  // map after this cycle
  map_t                next_tag;
  logic [num_regs-1:0] next_ready;

  // snapshot per rob slot
  // only tags are kept, a restored map is all ready
  map_t                ckpt_tag [num_rob];

  // completion still matches the live mapping
  logic                complete_hit;

  // register i maps to tag i
  function automatic map_t identity_map();
    map_t m;
    for (int i = 0; i < num_regs; i++) begin
      m[i] = tag_t'(i);
    end
    return m;
  endfunction

  // zero-latency lookups
  assign t_old    = map_tag[dest_reg];
  assign src1_tag = map_tag[src1_reg];
  assign src2_tag = map_tag[src2_reg];

  // ready from the table, the zero register, or a broadcast this very cycle
  assign src1_ready = map_ready[src1_reg] ||
                      (src1_reg == rename_arch_pkg::zero_reg) ||
                      (complete_en && (src1_tag == complete_tag));
  assign src2_ready = map_ready[src2_reg] ||
                      (src2_reg == rename_arch_pkg::zero_reg) ||
                      (complete_en && (src2_tag == complete_tag));

  // stale broadcasts are dropped
  // the register may have been renamed again since that tag was handed out
  assign complete_hit = complete_en && (map_tag[complete_reg] == complete_tag);

  always_comb begin
    next_tag   = map_tag;
    next_ready = map_ready;
    if (rollback_en) begin
      // everything older than the branch has its values, so all ready
      next_tag   = ckpt_tag[rollback_idx];
      next_ready = '1;
    end else begin
      // completion first
      if (complete_hit) begin
        next_ready[complete_reg] = 1'b1;
      end
      // then dispatch, which wins if both touch the same register
      if (dispatch_en) begin
        next_tag[dest_reg]   = t_new;
        next_ready[dest_reg] = 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      map_tag   <= identity_map();
      map_ready <= '1;
    end else begin
      map_tag   <= next_tag;
      map_ready <= next_ready;
    end
  end

  // snapshot of the post-dispatch map for this slot
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < num_rob; s++) begin
        ckpt_tag[s] <= identity_map();
      end
    end else if (dispatch_en) begin
      ckpt_tag[rob_idx] <= next_tag;
    end
  end

  // top holds off dispatch during rollback via stall
  assert property (@(posedge clock) disable iff (reset) !(dispatch_en && rollback_en))
    else $error("map_table: dispatch and rollback in the same cycle");

endmodule

// ==== rename_uarch_pkg.sv ====
// default physical register file and reorder buffer sizes of the rename stage
package rename_uarch_pkg;

  // physical register count
  // must exceed the architectural count so that free tags exist after reset
  // power of two, the free list pointers wrap on it
  localparam int default_num_pr = 64;

  // reorder buffer depth
  // one map checkpoint and one saved free list head per slot
  // power of two so that the slot index has no unused codes
  localparam int default_num_rob = 16;

endpackage

// ==== rename_arch_pkg.sv ====
// architectural register constants, register index type and zero register index
package rename_arch_pkg;

  // integer registers visible to software
  localparam int num_arch_regs = 32;

  // register index width follows from the register count
  localparam int arch_reg_w = $clog2(num_arch_regs);

  // register index as it comes out of the decoder
  typedef logic [arch_reg_w-1:0] arch_reg_t;

  // hardwired zero register
  // reads ready no matter which tag it maps to
  // dispatches that name it as destination still get a tag,
  // which keeps the old tag bookkeeping uniform
  localparam arch_reg_t zero_reg = arch_reg_t'(31);

  // map entries at reset follow the register index,
  // so tags 0 to num_arch_regs-1 start out in use

endpackage
